// ==== eth_tx_top.f ====
verilog/eth_pkg.sv
verilog/tx_payload_buf.sv
verilog/ether_tx.sv
verilog/bit_order.sv
verilog/crc32_gen.sv
verilog/eth_tx_top.sv
dv/clk_gen.sv
dv/eth_tx_tb.sv

// ==== Makefile ====
TOP = eth_tx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f eth_tx_top.f --top-module $(TOP) -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --top-module eth_tx_top \
	  verilog/eth_pkg.sv verilog/tx_payload_buf.sv verilog/ether_tx.sv \
	  verilog/bit_order.sv verilog/crc32_gen.sv verilog/eth_tx_top.sv

clean:
	rm -rf obj_dir sim.log

// ==== dv/eth_tx_tb.sv ====
`timescale 1ns/1ps

module eth_tx_tb import eth_pkg::*;;

  localparam int DATA_W  = 2;
  localparam int UNITS   = 8 / DATA_W;
  localparam int DEPTH   = 64;
  localparam int MAX_LEN = 40;
  localparam int FRAMES  = 9;
  // Worst case per frame plus the payload load time
  localparam int LIMIT   = FRAMES * ((8 + 14 + MAX_LEN + 4 + IPG_BYTES + 2) * UNITS
                           + 2 * MAX_LEN) + 400;
  localparam logic [31:0] RESIDUE = 32'hDEBB_20E3;

  logic clk, rst, hdr_valid, hdr_ready, pay_valid, pay_ready, tx_en;
  logic [DATA_W-1:0] txd;
  eth_hdr_t  hdr;
  pay_beat_t pay;

  logic [31:0] rng = 32'h6ad8_bca5;
  logic [7:0]  exp_q[$];
  logic [7:0]  cap_q[$];
  int          exp_len_q[$];
  int          cap_len_q[$];
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;
  int          idle_cnt = 1000;
  int          units = 0;
  int          frame_bytes = 0;
  logic [7:0]  cur = '0;
  bit          prev_en = 0;
  bit          in_tx = 0;
  bit          seen_frame = 0;
  bit          saw_full = 0;

  clk_gen u_clk (.clk(clk), .rst(rst));

  eth_tx_top #(.DATA_W(DATA_W), .FIFO_DEPTH(DEPTH)) UUT (
    .clk(clk), .rst(rst), .hdr(hdr), .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
    .pay(pay), .pay_valid(pay_valid), .pay_ready(pay_ready), .txd(txd), .tx_en(tx_en)
  );

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Reflected CRC-32 register over a byte range without the final inversion
  function automatic logic [31:0] crc_bytes(input logic [7:0] q[$], input int first);
    logic [31:0] c;
    c = CRC_INIT;
    for (int i = first; i < q.size(); i++) begin
      c = c ^ {24'h0, q[i]};
      for (int b = 0; b < 8; b++) c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // Random header and payload with the expected wire bytes queued
  task automatic make_frame(input int len, output eth_hdr_t h, output logic [7:0] p[$]);
    logic [7:0]  f[$];
    logic [31:0] c;
    rng = lcg(rng);
    h.dest_mac[47:16] = rng;
    rng = lcg(rng);
    h.dest_mac[15:0] = rng[31:16];
    h.src_mac[47:32] = rng[15:0];
    rng = lcg(rng);
    h.src_mac[31:0] = rng;
    rng = lcg(rng);
    h.etype = rng[23:8];
    p = {};
    for (int i = 0; i < len; i++) begin
      rng = lcg(rng);
      p.push_back(rng[23:16]);
    end
    for (int i = 0; i < PREAMBLE_LEN; i++) f.push_back(PREAMBLE_BYTE);
    f.push_back(SFD_BYTE);
    for (int i = 5; i >= 0; i--) f.push_back(h.dest_mac[i*8 +: 8]);
    for (int i = 5; i >= 0; i--) f.push_back(h.src_mac[i*8 +: 8]);
    f.push_back(h.etype[15:8]);
    f.push_back(h.etype[7:0]);
    f = {f, p};
    c = ~crc_bytes(f, 8);
    for (int i = 0; i < 4; i++) f.push_back(c[i*8 +: 8]);  // FCS low byte first
    exp_q = {exp_q, f};
    exp_len_q.push_back(f.size());
  endtask

  task automatic send_payload(input logic [7:0] p[$], input bit hdr_pending);
    for (int i = 0; i < p.size(); i++) begin
      pay.data  = p[i];
      pay.last  = (i == p.size() - 1);
      pay_valid = 1'b1;
      do begin
        @(posedge clk);
        if (!pay_ready) saw_full = 1;
        if (hdr_pending) begin
          check_eq("hdr_ready", hdr_ready, 0);  // Frame not complete yet
          check_eq("tx_en", tx_en, 0);
        end
      end while (!pay_ready);
      #1;
    end
    pay_valid = 1'b0;
  endtask

  task automatic send_header(input eth_hdr_t h);
    hdr       = h;
    hdr_valid = 1'b1;
    do @(posedge clk); while (!hdr_ready);
    #1 hdr_valid = 1'b0;
  endtask

  task automatic check_frame();
    int          n;
    logic [7:0]  got[$];
    while (cap_len_q.size() == 0) begin
      @(posedge clk);
      #1;
    end
    n = exp_len_q.pop_front();
    check_eq("frame length", cap_len_q.pop_front(), n);
    for (int i = 0; i < n; i++) begin
      got.push_back(cap_q.pop_front());
      check_eq($sformatf("txd byte %0d", i), got[i], exp_q.pop_front());
    end
    check_eq("crc residue", crc_bytes(got, 8), RESIDUE);
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: %s", name, (errors == err_before) ? "ok" : "FAILED");
  endtask

  // Frame capture, gap and hdr_ready watch, run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles, a frame never finished", cycles);
      $display("Checks failed");
      $finish;
    end else if (!rst) begin
      checks++;
      assert (!(hdr_ready && (in_tx || idle_cnt < IPG_BYTES * UNITS))) else begin
        errors++;
        $display("hdr_ready went high during a frame or its gap");
      end
      if (hdr_valid && hdr_ready) in_tx = 1;
      if (tx_en) begin
        if (!prev_en && seen_frame) begin
          checks++;
          assert (idle_cnt >= IPG_BYTES * UNITS) else begin
            errors++;
            $display("Interframe gap of %0d clocks is too short", idle_cnt);
          end
        end
        cur = {txd, cur[7:DATA_W]};  // LSB-first
        units++;
        if (units == UNITS) begin
          cap_q.push_back(cur);
          frame_bytes++;
          units = 0;
        end
        idle_cnt = 0;
      end else begin
        if (prev_en) begin
          cap_len_q.push_back(frame_bytes);
          frame_bytes = 0;
          units       = 0;
          in_tx       = 0;
          seen_frame  = 1;
        end
        if (idle_cnt < 1000) idle_cnt++;
      end
      prev_en = tx_en;
    end
  end

  initial begin
    eth_hdr_t   ha, hb;
    logic [7:0] pa[$], pb[$];
    int         e;
    hdr       = '0;
    hdr_valid = 0;
    pay       = '0;
    pay_valid = 0;
    @(negedge rst);
    e = errors;
    repeat (12) begin
      @(posedge clk);
      check_eq("tx_en", tx_en, 0);
      check_eq("txd", txd, 0);
      check_eq("pay_ready", pay_ready, 1);
    end
    #1 report_test("test 1 reset state", e);

    e = errors;
    make_frame(20, ha, pa);
    send_payload(pa, 0);
    send_header(ha);
    check_frame();
    report_test("test 2 single frame", e);

    e = errors;
    for (int k = 0; k < 5; k++) begin
      rng = lcg(rng);
      make_frame(1 + int'(rng[23:16]) % MAX_LEN, ha, pa);
      send_payload(pa, 0);
      send_header(ha);
      check_frame();
    end
    report_test("test 3 FCS and gap on random frames", e);

    e = errors;
    make_frame(17, ha, pa);
    hdr = ha;
    hdr_valid = 1'b1;  // Header offered ahead of its payload
    send_payload(pa, 1);
    send_header(ha);
    check_frame();
    report_test("test 4 header before payload", e);

    e = errors;
    make_frame(MAX_LEN, ha, pa);
    make_frame(30, hb, pb);
    fork
      begin
        send_payload(pa, 0);
        send_payload(pb, 0);
      end
      send_header(ha);
    join
    checks++;
    assert (saw_full) else begin
      errors++;
      $display("pay_ready never fell with a full buffer");
    end
    check_frame();
    send_header(hb);
    check_frame();
    report_test("test 5 full buffer back-pressure", e);

    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
  end

  always #2 clk = ~clk;  // 4 ns period

endmodule

// ==== verilog/eth_tx_top.sv ====
`timescale 1ns/1ps

module eth_tx_top import eth_pkg::*; #(
  parameter int DATA_W     = 2,   // 2 for RMII, 4 for MII
  parameter int FIFO_DEPTH = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  eth_hdr_t          hdr,
  input  logic              hdr_valid,
  output logic              hdr_ready,
  input  pay_beat_t         pay,
  input  logic              pay_valid,
  output logic              pay_ready,
  output logic [DATA_W-1:0] txd,
  output logic              tx_en
);

  logic              frame_avail;
  logic              rd_en;
  pay_beat_t         rd_beat;
  logic [DATA_W-1:0] seq_data;
  line_flags_t       seq_flags;
  logic [DATA_W-1:0] ord_data;
  line_flags_t       ord_flags;

  tx_payload_buf #(.FIFO_DEPTH(FIFO_DEPTH)) u_buf (
    .clk         (clk),
    .rst         (rst),
    .pay         (pay),
    .pay_valid   (pay_valid),
    .pay_ready   (pay_ready),
    .rd_en       (rd_en),
    .rd_beat     (rd_beat),
    .frame_avail (frame_avail)
  );

  // Frame sequencer, MSB-first units
  ether_tx #(.DATA_W(DATA_W)) u_seq (
    .clk         (clk),
    .rst         (rst),
    .hdr         (hdr),
    .hdr_valid   (hdr_valid),
    .hdr_ready   (hdr_ready),
    .frame_avail (frame_avail),
    .rd_beat     (rd_beat),
    .rd_en       (rd_en),
    .seq_data    (seq_data),
    .seq_flags   (seq_flags)
  );

  bit_order #(.DATA_W(DATA_W)) u_order (
    .clk       (clk),
    .rst       (rst),
    .seq_data  (seq_data),
    .seq_flags (seq_flags),
    .ord_data  (ord_data),
    .ord_flags (ord_flags)
  );

  crc32_gen #(.DATA_W(DATA_W)) u_crc (
    .clk       (clk),
    .rst       (rst),
    .ord_data  (ord_data),
    .ord_flags (ord_flags),
    .txd       (txd),
    .tx_en     (tx_en)
  );

endmodule

// ==== verilog/crc32_gen.sv ====
`timescale 1ns/1ps

module crc32_gen import eth_pkg::*; #(
  parameter int DATA_W = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] ord_data,
  input  line_flags_t       ord_flags,
  output logic [DATA_W-1:0] txd,
  output logic              tx_en
);

  localparam int FCS_UNITS = 32 / DATA_W;
  localparam int FCNT_W    = $clog2(FCS_UNITS);

  logic [31:0]       crc;
  logic              fcs_active;  // Shifting the FCS onto the line
  logic [FCNT_W-1:0] fcs_cnt;

  // Serial update, txd[0] first as on the wire
  function automatic logic [31:0] crc_step(input logic [31:0] c_in,
                                           input logic [DATA_W-1:0] d);
    logic [31:0] c;
    c = c_in;
    for (int i = 0; i < DATA_W; i++) begin
      if (c[0] ^ d[i]) begin
        c = (c >> 1) ^ CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      crc        <= CRC_INIT;
      fcs_active <= 1'b0;
      fcs_cnt    <= '0;
    end else if (fcs_active) begin
      crc     <= crc >> DATA_W;  // Next FCS unit into the low bits
      fcs_cnt <= fcs_cnt + 1'b1;
      if (fcs_cnt == FCNT_W'(FCS_UNITS - 1)) begin
        fcs_active <= 1'b0;
      end
    end else if (ord_flags.en) begin
      // Preamble and SFD pass with the register untouched
      if (ord_flags.cksum) begin
        crc <= crc_step(crc, ord_data);
      end
      if (ord_flags.last) begin
        fcs_active <= 1'b1;
        fcs_cnt    <= '0;
      end
    end else begin
      crc <= CRC_INIT;  // Idle line, ready for the next frame
    end
  end

  // Frame units go straight through
  always_comb begin
    tx_en = ord_flags.en | fcs_active;
    if (fcs_active) begin
      txd = ~crc[DATA_W-1:0];
    end else if (ord_flags.en) begin
      txd = ord_data;
    end else begin
      txd = '0;
    end
  end

endmodule

// ==== verilog/bit_order.sv ====
`timescale 1ns/1ps

module bit_order import eth_pkg::*; #(
  parameter int DATA_W = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] seq_data,
  input  line_flags_t       seq_flags,
  output logic [DATA_W-1:0] ord_data,   // LSB-first wire order
  output line_flags_t       ord_flags
);

  localparam int UNITS = 8 / DATA_W;
  localparam int PH_W  = $clog2(UNITS);

  logic [PH_W-1:0] in_phase;
  logic [PH_W-1:0] out_phase;
  logic [7:0]      gather;     // Byte being collected
  logic [7:0]      byte_now;
  logic [7:0]      out_byte;   // Byte being played out
  logic            load;
  line_flags_t     out_flags;

  assign load = seq_flags.en && (in_phase == PH_W'(UNITS - 1));

  // First unit in lands in the top bits
  always_comb begin
    byte_now = gather;
    byte_now[(UNITS - 1 - in_phase) * DATA_W +: DATA_W] = seq_data;
  end

  always_ff @(posedge clk) begin
    gather <= byte_now;
    if (load) out_byte <= byte_now;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_phase  <= '0;
      out_phase <= '0;
      out_flags <= '0;
    end else begin
      if (seq_flags.en) in_phase <= in_phase + 1'b1;

      if (load) begin
        out_flags.en    <= 1'b1;
        out_flags.cksum <= seq_flags.cksum;
        out_flags.last  <= seq_flags.last;
        out_phase       <= '0;
      end else if (out_flags.en) begin
        out_phase <= out_phase + 1'b1;
        if (out_phase == PH_W'(UNITS - 1)) out_flags <= '0;  // Byte drained with nothing behind it
      end
    end
  end

  // Low unit first and txd[0] carries the earlier bit
  assign ord_data        = out_flags.en ? out_byte[out_phase * DATA_W +: DATA_W] : '0;
  assign ord_flags.en    = out_flags.en;
  assign ord_flags.cksum = out_flags.cksum;
  assign ord_flags.last  = out_flags.last && (out_phase == PH_W'(UNITS - 1));

endmodule

// ==== verilog/ether_tx.sv ====
`timescale 1ns/1ps

module ether_tx import eth_pkg::*; #(
  parameter int DATA_W = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  eth_hdr_t          hdr,
  input  logic              hdr_valid,
  output logic              hdr_ready,
  input  logic              frame_avail,
  input  pay_beat_t         rd_beat,
  output logic              rd_en,
  output logic [DATA_W-1:0] seq_data,   // MSB-first units
  output line_flags_t       seq_flags
);

  localparam int UNITS     = 8 / DATA_W;  // Units per byte
  localparam int UPOS_W    = $clog2(UNITS);
  localparam int FCS_BYTES = 4;
  // Covers the reorder delay, the FCS and the IPG, plus the CRC stage edge
  localparam int GAP_UNITS = (IPG_BYTES + FCS_BYTES + 1) * UNITS + 1;
  localparam int GAP_W     = $clog2(GAP_UNITS + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_PREAMBLE,
    S_SFD,
    S_DST_MAC,
    S_SRC_MAC,
    S_TYPE,
    S_DATA,
    S_GAP
  } state_t;

  state_t            state;
  eth_hdr_t          hdr_q;
  logic [UPOS_W-1:0] upos;      // Unit within the current byte
  logic [2:0]        bcnt;      // Byte within the current field
  logic [GAP_W-1:0]  gap_cnt;
  logic [7:0]        cur_byte;
  logic              byte_end;
  logic              in_frame;

  assign hdr_ready = (state == S_IDLE) && frame_avail;
  assign byte_end  = (upos == UPOS_W'(UNITS - 1));
  assign in_frame  = (state != S_IDLE) && (state != S_GAP);
  assign rd_en     = (state == S_DATA) && byte_end;  // Pop once the byte is sent

  // Byte being sent in this state
  always_comb begin
    case (state)
      S_PREAMBLE: cur_byte = PREAMBLE_BYTE;
      S_SFD:      cur_byte = SFD_BYTE;
      S_DST_MAC:  cur_byte = hdr_q.dest_mac[(5 - bcnt) * 8 +: 8];
      S_SRC_MAC:  cur_byte = hdr_q.src_mac[(5 - bcnt) * 8 +: 8];
      S_TYPE:     cur_byte = hdr_q.etype[(1 - bcnt) * 8 +: 8];
      S_DATA:     cur_byte = rd_beat.data;
      default:    cur_byte = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (hdr_valid && hdr_ready) begin
      hdr_q <= hdr;  // Held for the whole frame
    end
    if (in_frame) begin
      seq_data <= cur_byte[(UNITS - 1 - upos) * DATA_W +: DATA_W];
    end else begin
      seq_data <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      upos      <= '0;
      bcnt      <= '0;
      gap_cnt   <= '0;
      seq_flags <= '0;
    end else begin
      seq_flags <= '0;
      case (state)
        S_IDLE: begin
          if (hdr_valid && hdr_ready) begin
            state <= S_PREAMBLE;
            upos  <= '0;
            bcnt  <= '0;
          end
        end

        S_GAP: begin
          if (gap_cnt == GAP_W'(GAP_UNITS - 1)) begin
            gap_cnt <= '0;
            state   <= S_IDLE;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end

        default: begin
          seq_flags.en    <= 1'b1;
          seq_flags.cksum <= (state != S_PREAMBLE) && (state != S_SFD);
          seq_flags.last  <= (state == S_DATA) && byte_end && rd_beat.last;
          upos            <= upos + 1'b1;
          if (byte_end) begin
            bcnt <= bcnt + 1'b1;
            case (state)
              S_PREAMBLE: begin
                if (bcnt == 3'(PREAMBLE_LEN - 1)) begin
                  state <= S_SFD;
                  bcnt  <= '0;
                end
              end
              S_SFD: begin
                state <= S_DST_MAC;
                bcnt  <= '0;
              end
              S_DST_MAC: begin
                if (bcnt == 3'd5) begin
                  state <= S_SRC_MAC;
                  bcnt  <= '0;
                end
              end
              S_SRC_MAC: begin
                if (bcnt == 3'd5) begin
                  state <= S_TYPE;
                  bcnt  <= '0;
                end
              end
              S_TYPE: begin
                if (bcnt == 3'd1) state <= S_DATA;
              end
              default: begin
                if (rd_beat.last) state <= S_GAP;  // FCS follows from crc32_gen
              end
            endcase
          end
        end
      endcase
    end
  end

endmodule

// ==== verilog/tx_payload_buf.sv ====
`timescale 1ns/1ps

module tx_payload_buf import eth_pkg::*; #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic      clk,
  input  logic      rst,
  input  pay_beat_t pay,
  input  logic      pay_valid,
  output logic      pay_ready,
  input  logic      rd_en,
  output pay_beat_t rd_beat,
  output logic      frame_avail
);

  localparam int AW = $clog2(FIFO_DEPTH);

  pay_beat_t      mem [FIFO_DEPTH];
  logic [AW:0]    wr_ptr;     // Extra bit tells full from empty
  logic [AW:0]    rd_ptr;
  logic [AW:0]    frame_cnt;  // Complete frames held
  logic           full;
  logic           empty;
  logic           push;
  logic           pop;

  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  assign pay_ready = !full;
  assign push      = pay_valid && pay_ready;
  assign pop       = rd_en && !empty;

  assign rd_beat     = mem[rd_ptr[AW-1:0]];  // Head of queue, show-ahead
  assign frame_avail = (frame_cnt != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= pay;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      frame_cnt <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;

      // A frame counts once its last byte is in, and leaves with that byte
      case ({push && pay.last, pop && rd_beat.last})
        2'b10:   frame_cnt <= frame_cnt + 1'b1;
        2'b01:   frame_cnt <= frame_cnt - 1'b1;
        default: frame_cnt <= frame_cnt;
      endcase
    end
  end

endmodule

// ==== verilog/eth_pkg.sv ====
package eth_pkg;

  // Header request, fields leave in declaration order
  typedef struct packed {
    logic [47:0] dest_mac;
    logic [47:0] src_mac;
    logic [15:0] etype;
  } eth_hdr_t;

  // One payload byte
  typedef struct packed {
    logic [7:0] data;
    logic       last;  // Final byte of the frame
  } pay_beat_t;

  // Side flags that follow each line unit down the pipe
  typedef struct packed {
    logic en;     // Unit belongs to a frame
    logic cksum;  // Unit is covered by the FCS
    logic last;   // Final payload unit
  } line_flags_t;

  // Framing
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;
  localparam int         PREAMBLE_LEN  = 7;

  // Idle byte times after the FCS
  localparam int IPG_BYTES = 12;

  // Reflected CRC-32, shifted right one bit at a time
  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;
  localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

endpackage
